//--- design/simt_alu_pkg.sv
package simt_alu_pkg;

    localparam int num_threads = 4;
    localparam int xlen        = 32;
    localparam int nw_bits     = 2;
    localparam int nr_bits     = 5;
    localparam int uuid_bits   = 8;

    typedef enum logic [1:0] {
        OPK_ALU = 2'd0,
        OPK_BR  = 2'd1,
        OPK_MUL = 2'd2
    } op_kind_e;

    // Bits 3:2 select the class, bit 0 marks signed
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLTU = 4'b0100,
        ALU_SLT  = 4'b0101,
        ALU_SRL  = 4'b1000,
        ALU_SRA  = 4'b1001,
        ALU_SUB  = 4'b1011,
        ALU_AND  = 4'b1100,
        ALU_OR   = 4'b1101,
        ALU_XOR  = 4'b1110,
        ALU_SLL  = 4'b1111
    } alu_op_e;

    typedef struct packed {
        logic is_static;
        logic is_unsigned;
        logic is_less;
        logic is_neg;
    } br_op_t;

    localparam br_op_t BR_BEQ  = 4'b0000;
    localparam br_op_t BR_BNE  = 4'b0001;
    localparam br_op_t BR_BLT  = 4'b0010;
    localparam br_op_t BR_BGE  = 4'b0011;
    localparam br_op_t BR_BLTU = 4'b0110;
    localparam br_op_t BR_BGEU = 4'b0111;
    localparam br_op_t BR_JAL  = 4'b1000;
    localparam br_op_t BR_JALR = 4'b1001;   // Spare neg bit marks JALR

    typedef enum logic [3:0] {
        MUL   = 4'd0,
        MULHU = 4'd1,
        DIVU  = 4'd2,
        REMU  = 4'd3
    } mul_op_e;

    // Read according to op_kind_e
    typedef union packed {
        alu_op_e alu;
        br_op_t  br;
        mul_op_e mul;
    } op_u;

    typedef struct packed {
        logic [uuid_bits-1:0]             uuid;
        logic [nw_bits-1:0]               wid;
        logic [num_threads-1:0]           tmask;
        logic [31:0]                      pc;
        logic [31:0]                      next_pc;
        op_kind_e                         kind;
        op_u                              op;
        logic                             use_pc;
        logic                             use_imm;
        logic [xlen-1:0]                  imm;
        logic [nr_bits-1:0]               rd;
        logic                             wb;
        logic [$clog2(num_threads)-1:0]   tid;    // Lane that resolves a branch
        logic [num_threads-1:0][xlen-1:0] rs1_data;
        logic [num_threads-1:0][xlen-1:0] rs2_data;
    } alu_req_t;

    typedef struct packed {
        logic [uuid_bits-1:0]             uuid;
        logic [nw_bits-1:0]               wid;
        logic [num_threads-1:0]           tmask;
        logic [31:0]                      pc;
        logic [nr_bits-1:0]               rd;
        logic                             wb;
        logic [num_threads-1:0][xlen-1:0] data;
    } commit_t;

    typedef struct packed {
        logic [nw_bits-1:0] wid;
        logic               taken;
        logic [31:0]        dest;
    } branch_ctl_t;

endpackage

//--- design/alu_lane.sv
`timescale 1ns/100ps

module alu_lane (
    input  simt_alu_pkg::alu_op_e op,
    input  logic                  is_br,
    input  simt_alu_pkg::br_op_t  br,
    input  logic [31:0]           in1_pc,
    input  logic [31:0]           in2_imm,
    input  logic [31:0]           in2_cmp,
    input  logic [31:0]           in1,
    output logic [31:0]           result,
    output logic [31:0]           sum,
    output logic                  less,
    output logic                  equal
);
    import simt_alu_pkg::*;

    logic        cmp_signed;
    logic [32:0] diff;
    logic [31:0] shr;
    logic [31:0] msc;

    assign cmp_signed = is_br ? ~br.is_unsigned : op[0];

    assign sum  = in1_pc + in2_imm;
    assign diff = {cmp_signed & in1[31], in1} - {cmp_signed & in2_cmp[31], in2_cmp};
    assign shr  = 32'($signed({op[0] & in1[31], in1}) >>> in2_imm[4:0]);   // Sign fill for SRA

    always_comb begin
        case (op)
            ALU_AND: msc = in1 & in2_imm;
            ALU_OR:  msc = in1 | in2_imm;
            ALU_XOR: msc = in1 ^ in2_imm;
            default: msc = in1 << in2_imm[4:0];
        endcase
    end

    always_comb begin
        case (op[3:2])
            2'b00:   result = sum;
            2'b01:   result = {31'b0, diff[32]};
            2'b10:   result = (op == ALU_SUB) ? diff[31:0] : shr;
            default: result = msc;
        endcase
    end

    // Borrow of the extended difference is the less-than flag
    assign less  = diff[32];
    assign equal = (diff[31:0] == 32'b0);

endmodule

//--- design/alu_pipe.sv
`timescale 1ns/100ps

module alu_pipe (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      in_valid,
    input  simt_alu_pkg::alu_req_t    req,
    output logic                      in_ready,
    output logic                      out_valid,
    output simt_alu_pkg::commit_t     out,
    input  logic                      out_ready,
    output logic                      branch_valid,
    output simt_alu_pkg::branch_ctl_t branch
);
    import simt_alu_pkg::*;

    logic                             is_br;
    logic                             is_jal;
    logic [num_threads-1:0][xlen-1:0] in1_pc;
    logic [num_threads-1:0][xlen-1:0] in2_imm;
    logic [num_threads-1:0][xlen-1:0] in2_cmp;
    logic [num_threads-1:0][xlen-1:0] lane_result;
    logic [num_threads-1:0][xlen-1:0] lane_sum;
    logic [num_threads-1:0][xlen-1:0] data_next;
    logic [num_threads-1:0]           lane_less;
    logic [num_threads-1:0]           lane_equal;
    logic                             is_br_q;
    br_op_t                           br_q;
    logic                             less_q;
    logic                             equal_q;
    logic [31:0]                      dest_q;

    assign is_br    = (req.kind == OPK_BR);
    assign is_jal   = is_br && req.op.br.is_static;
    assign in_ready = !out_valid || out_ready;

    for (genvar i = 0; i < num_threads; i++) begin : g_lane
        assign in1_pc[i]  = req.use_pc ? req.pc : req.rs1_data[i];
        assign in2_imm[i] = req.use_imm ? req.imm : req.rs2_data[i];
        assign in2_cmp[i] = (req.use_imm && !is_br) ? req.imm : req.rs2_data[i];  // Branches use rs2

        alu_lane u_alu_lane (
            .op      (req.op.alu),
            .is_br   (is_br),
            .br      (req.op.br),
            .in1_pc  (in1_pc[i]),
            .in2_imm (in2_imm[i]),
            .in2_cmp (in2_cmp[i]),
            .in1     (req.rs1_data[i]),
            .result  (lane_result[i]),
            .sum     (lane_sum[i]),
            .less    (lane_less[i]),
            .equal   (lane_equal[i])
        );

        assign data_next[i] = is_jal ? req.next_pc : lane_result[i];   // Link address
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out.uuid  <= req.uuid;
            out.wid   <= req.wid;
            out.tmask <= req.tmask;
            out.pc    <= req.pc;
            out.rd    <= req.rd;
            out.wb    <= req.wb;
            out.data  <= data_next;
            is_br_q   <= is_br;
            br_q      <= req.op.br;
            less_q    <= lane_less[req.tid];
            equal_q   <= lane_equal[req.tid];
            dest_q    <= lane_sum[req.tid];
        end
    end

    // Pulses on the handoff into the arbiter
    assign branch_valid = out_valid && out_ready && is_br_q;
    assign branch.wid   = out.wid;
    assign branch.taken = ((br_q.is_less ? less_q : equal_q) ^ br_q.is_neg) | br_q.is_static;
    assign branch.dest  = dest_q;

endmodule

//--- design/muldiv_unit.sv
`timescale 1ns/100ps

module muldiv_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  simt_alu_pkg::alu_req_t req,
    output logic                   in_ready,
    output logic                   out_valid,
    output simt_alu_pkg::commit_t  out,
    input  logic                   out_ready
);
    import simt_alu_pkg::*;

    logic                             busy_q;
    logic [5:0]                       cnt_q;
    mul_op_e                          op_q;
    logic                             is_div;
    logic [num_threads-1:0][xlen-1:0] a_q;      // Dividend/quotient or product low
    logic [num_threads-1:0][xlen-1:0] b_q;
    logic [num_threads-1:0][xlen-1:0] r_q;      // Remainder or product high
    logic [num_threads-1:0][xlen:0]   rem_shift;
    logic [num_threads-1:0][xlen+1:0] trial;
    logic [num_threads-1:0][xlen-1:0] step_a;
    logic [num_threads-1:0][xlen-1:0] step_r;
    logic [num_threads-1:0][xlen-1:0] data_next;

    assign is_div   = (op_q == DIVU) || (op_q == REMU);
    assign in_ready = !busy_q && (!out_valid || out_ready);

    // A zero divisor always subtracts, so the quotient is all ones and r keeps the dividend
    for (genvar i = 0; i < num_threads; i++) begin : g_lane
        assign rem_shift[i] = {r_q[i], a_q[i][xlen-1]};
        assign trial[i]     = {1'b0, rem_shift[i]} - {2'b0, b_q[i]};
        assign data_next[i] = (op_q == MULHU || op_q == REMU) ? r_q[i] : a_q[i];
    end

    always_comb begin
        for (int i = 0; i < num_threads; i++) begin
            if (is_div) begin
                step_r[i] = trial[i][xlen+1] ? rem_shift[i][xlen-1:0] : trial[i][xlen-1:0];
                step_a[i] = {a_q[i][xlen-2:0], ~trial[i][xlen+1]};
            end else begin
                {step_r[i], step_a[i]} = (2*xlen)'(a_q[i]) * (2*xlen)'(b_q[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q    <= 1'b0;
            cnt_q     <= '0;
            out_valid <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            if (in_valid && in_ready) begin
                busy_q <= 1'b1;
                cnt_q  <= (req.op.mul == DIVU || req.op.mul == REMU) ? 6'd32 : 6'd1;
            end else if (busy_q) begin
                if (cnt_q == 6'd0) begin
                    busy_q    <= 1'b0;
                    out_valid <= 1'b1;
                end else begin
                    cnt_q <= cnt_q - 6'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            op_q      <= req.op.mul;
            a_q       <= req.rs1_data;
            b_q       <= req.rs2_data;
            r_q       <= '0;
            out.uuid  <= req.uuid;
            out.wid   <= req.wid;
            out.tmask <= req.tmask;
            out.pc    <= req.pc;
            out.rd    <= req.rd;
            out.wb    <= req.wb;
        end else if (busy_q) begin
            if (cnt_q != 6'd0) begin
                a_q <= step_a;
                r_q <= step_r;
            end else begin
                out.data <= data_next;   // Final cycle picks the half
            end
        end
    end

endmodule

//--- design/commit_arb.sv
`timescale 1ns/100ps

module commit_arb (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [1:0]                  in_valid,
    input  simt_alu_pkg::commit_t [1:0] in,
    output logic [1:0]                  in_ready,
    output logic                        out_valid,
    output simt_alu_pkg::commit_t       out,
    input  logic                        out_ready
);

    logic prio_q;      // Input that wins a tie
    logic can_load;
    logic gnt_any;
    logic gnt_idx;

    assign can_load = !out_valid || out_ready;
    assign gnt_any  = |in_valid;
    assign gnt_idx  = in_valid[prio_q] ? prio_q : ~prio_q;

    assign in_ready[0] = can_load && gnt_any && !gnt_idx;
    assign in_ready[1] = can_load && gnt_any && gnt_idx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            prio_q    <= 1'b0;
        end else if (can_load) begin
            out_valid <= gnt_any;
            if (gnt_any) begin
                prio_q <= ~gnt_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_load && gnt_any) begin
            out <= in[gnt_idx];
        end
    end

endmodule

//--- design/simt_alu_unit.sv
`timescale 1ns/100ps

module simt_alu_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  simt_alu_pkg::alu_req_t    req,
    output logic                      req_ready,
    output logic                      commit_valid,
    output simt_alu_pkg::commit_t     commit,
    input  logic                      commit_ready,
    output logic                      branch_valid,
    output simt_alu_pkg::branch_ctl_t branch
);
    import simt_alu_pkg::*;

    logic           is_mul;
    logic           alu_in_ready;
    logic           mul_in_ready;
    logic [1:0]     arb_valid;
    logic [1:0]     arb_ready;
    commit_t [1:0]  arb_data;

    assign is_mul    = (req.kind == OPK_MUL);
    assign req_ready = is_mul ? mul_in_ready : alu_in_ready;

    alu_pipe u_alu_pipe (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (req_valid && !is_mul),
        .req          (req),
        .in_ready     (alu_in_ready),
        .out_valid    (arb_valid[0]),
        .out          (arb_data[0]),
        .out_ready    (arb_ready[0]),
        .branch_valid (branch_valid),
        .branch       (branch)
    );

    muldiv_unit u_muldiv_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid && is_mul),
        .req       (req),
        .in_ready  (mul_in_ready),
        .out_valid (arb_valid[1]),
        .out       (arb_data[1]),
        .out_ready (arb_ready[1])
    );

    commit_arb u_commit_arb (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (arb_valid),
        .in        (arb_data),
        .in_ready  (arb_ready),
        .out_valid (commit_valid),
        .out       (commit),
        .out_ready (commit_ready)
    );

endmodule

//--- include/simt_alu_model.svh
`ifndef SIMT_ALU_MODEL_SVH
`define SIMT_ALU_MODEL_SVH

// Expected commit data of one lane
function automatic logic [31:0] model_lane(simt_alu_pkg::alu_req_t req, int i);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] op1;
    logic [31:0] op2;
    logic [31:0] cmp;
    logic        sgn;
    logic        lt;
    a   = req.rs1_data[i];
    b   = req.rs2_data[i];
    op1 = req.use_pc ? req.pc : a;
    op2 = req.use_imm ? req.imm : b;
    cmp = (req.use_imm && req.kind != simt_alu_pkg::OPK_BR) ? req.imm : b;
    sgn = (req.kind == simt_alu_pkg::OPK_BR) ? !req.op.br.is_unsigned : req.op.alu[0];
    lt  = sgn ? ($signed(a) < $signed(cmp)) : (a < cmp);
    if (req.kind == simt_alu_pkg::OPK_MUL) begin
        case (req.op.mul)
            simt_alu_pkg::MUL:   return 32'(64'(a) * 64'(b));
            simt_alu_pkg::MULHU: return 32'((64'(a) * 64'(b)) >> 32);
            simt_alu_pkg::DIVU:  return (b == 0) ? 32'hffff_ffff : a / b;
            default:             return (b == 0) ? a : a % b;
        endcase
    end
    if (req.kind == simt_alu_pkg::OPK_BR && req.op.br.is_static) begin
        return req.next_pc;
    end
    // Decoded by class, same as the lane
    case (req.op.alu[3:2])
        2'b00: return op1 + op2;
        2'b01: return {31'b0, lt};
        2'b10: begin
            if (req.op.alu == simt_alu_pkg::ALU_SUB) begin
                return a - cmp;
            end
            return req.op.alu[0] ? 32'($signed(a) >>> op2[4:0]) : a >> op2[4:0];
        end
        default: begin
            case (req.op.alu)
                simt_alu_pkg::ALU_AND: return a & op2;
                simt_alu_pkg::ALU_OR:  return a | op2;
                simt_alu_pkg::ALU_XOR: return a ^ op2;
                default:               return a << op2[4:0];
            endcase
        end
    endcase
endfunction

function automatic logic model_taken(simt_alu_pkg::alu_req_t req);
    logic [31:0] a;
    logic [31:0] b;
    logic        lt;
    a  = req.rs1_data[req.tid];
    b  = req.rs2_data[req.tid];
    lt = req.op.br.is_unsigned ? (a < b) : ($signed(a) < $signed(b));
    if (req.op.br.is_static) begin
        return 1'b1;
    end
    return (req.op.br.is_less ? lt : (a == b)) ^ req.op.br.is_neg;
endfunction

function automatic logic [31:0] model_dest(simt_alu_pkg::alu_req_t req);
    logic [31:0] base;
    logic [31:0] offs;
    base = req.use_pc ? req.pc : req.rs1_data[req.tid];
    offs = req.use_imm ? req.imm : req.rs2_data[req.tid];
    return base + offs;
endfunction

`endif

//--- verif/simt_alu_tb.sv
`timescale 1ns/100ps

module simt_alu_tb;
    import simt_alu_pkg::*;

    `include "simt_alu_model.svh"

    localparam int num_reqs      = 240;
    localparam int timeout_cycles = num_reqs * 40 + 300;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    alu_req_t    req;
    logic        req_ready;
    logic        commit_valid;
    commit_t     commit;
    logic        commit_ready;
    logic        branch_valid;
    branch_ctl_t branch;

    commit_t     exp_tab [256];    // Expected commit by uuid
    bit          pending [256];
    branch_ctl_t exp_br [$];       // ALU pipe keeps branch order
    int          outstanding;
    int          sent;
    int          committed;
    int          branches;
    int          value_err;
    int          proto_err;
    int          uuid_cnt;
    bit          stall_en;
    bit          hold;
    commit_t     held;

    alu_op_e  alu_ops [10] = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
                               ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA};
    br_op_t   br_ops [8]   = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU,
                               BR_JAL, BR_JALR};
    mul_op_e  mul_ops [4]  = '{MUL, MULHU, DIVU, REMU};
    op_kind_e kinds [3]    = '{OPK_ALU, OPK_BR, OPK_MUL};

    simt_alu_unit u_simt_alu_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready),
        .branch_valid (branch_valid),
        .branch       (branch)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reference result of a whole request
    function automatic commit_t expected_commit(alu_req_t r);
        commit_t c;
        c.uuid  = r.uuid;
        c.wid   = r.wid;
        c.tmask = r.tmask;
        c.pc    = r.pc;
        c.rd    = r.rd;
        c.wb    = r.wb;
        for (int i = 0; i < num_threads; i++) begin
            c.data[i] = model_lane(r, i);
        end
        return c;
    endfunction

    function automatic alu_req_t make_req(op_kind_e kind, int sel, logic [7:0] uuid);
        alu_req_t r;
        r         = '0;
        r.uuid    = uuid;
        r.wid     = 2'($urandom);
        r.tmask   = 4'($urandom);
        r.pc      = $urandom & 32'hffff_fffc;
        r.next_pc = r.pc + 32'd4;
        r.kind    = kind;
        r.use_pc  = 1'($urandom);
        r.use_imm = 1'($urandom);
        r.imm     = ($urandom % 2 == 0) ? 32'($signed(12'($urandom))) : $urandom;
        r.rd      = 5'($urandom);
        r.wb      = 1'($urandom);
        r.tid     = 2'($urandom);
        for (int i = 0; i < num_threads; i++) begin
            r.rs1_data[i] = $urandom;
            r.rs2_data[i] = $urandom >> ($urandom % 32);   // Small divisors too
        end
        case (kind)
            OPK_ALU: r.op.alu = alu_ops[sel % 10];
            OPK_BR: begin
                r.op.br   = br_ops[sel % 8];
                r.use_imm = 1'b1;
                r.use_pc  = (r.op.br != BR_JALR);
                if ($urandom % 2 == 0) begin
                    r.rs2_data[r.tid] = r.rs1_data[r.tid];
                end
            end
            default: begin
                r.op.mul  = mul_ops[sel % 4];
                r.use_pc  = 1'b0;
                r.use_imm = 1'b0;
                for (int i = 0; i < num_threads; i++) begin
                    if ($urandom % 4 == 0) begin
                        r.rs2_data[i] = 32'd0;
                    end else if ($urandom % 4 == 0) begin
                        r.rs1_data[i] = 32'd0;
                    end
                end
            end
        endcase
        return r;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        assert (got === exp) else begin
            $display("ERROR %0t %s exp %h got %h", $time, name, exp, got);
            value_err++;
        end
    endtask

    task automatic record_req(input alu_req_t r);
        branch_ctl_t b;
        exp_tab[r.uuid] = expected_commit(r);
        pending[r.uuid] = 1'b1;
        outstanding++;
        sent++;
        if (r.kind == OPK_BR) begin
            b.wid   = r.wid;
            b.taken = model_taken(r);
            b.dest  = model_dest(r);
            exp_br.push_back(b);
        end
    endtask

    task automatic send_req(input alu_req_t r);
        req       = r;
        req_valid = 1'b1;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        record_req(r);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    // mode 0..2 picks one kind, 3 mixes them
    task automatic run_phase(input int count, input int mode, input bit gaps);
        op_kind_e kind;
        for (int n = 0; n < count; n++) begin
            kind = (mode == 3) ? kinds[$urandom % 3] : kinds[mode];
            send_req(make_req(kind, (mode == 3) ? int'($urandom % 64) : n, 8'(uuid_cnt)));
            uuid_cnt++;
            if (gaps && ($urandom % 4 == 0)) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic check_commit(input commit_t c);
        commit_t e;
        assert (pending[c.uuid]) else begin
            $display("commit for uuid %0d which is not in flight", c.uuid);
            proto_err++;
        end
        if (pending[c.uuid]) begin
            e = exp_tab[c.uuid];
            compare_field("commit.wid", 32'(e.wid), 32'(c.wid));
            compare_field("commit.tmask", 32'(e.tmask), 32'(c.tmask));
            compare_field("commit.pc", e.pc, c.pc);
            compare_field("commit.rd", 32'(e.rd), 32'(c.rd));
            compare_field("commit.wb", 32'(e.wb), 32'(c.wb));
            for (int i = 0; i < num_threads; i++) begin
                compare_field($sformatf("commit.data[%0d]", i), e.data[i], c.data[i]);
            end
            pending[c.uuid] = 1'b0;
            outstanding--;
            committed++;
        end
    endtask

    task automatic check_branch(input branch_ctl_t b);
        branch_ctl_t e;
        assert (exp_br.size() > 0) else begin
            $display("branch_valid pulsed with no branch in flight");
            proto_err++;
        end
        if (exp_br.size() > 0) begin
            e = exp_br.pop_front();
            compare_field("branch.wid", 32'(e.wid), 32'(b.wid));
            compare_field("branch.taken", 32'(e.taken), 32'(b.taken));
            compare_field("branch.dest", e.dest, b.dest);
            branches++;
        end
    endtask

    // Monitor at the falling edge, where everything is settled
    always @(negedge clk) begin
        if (rst_n) begin
            if (hold) begin
                assert (commit_valid && commit == held) else begin
                    $display("commit changed or dropped while commit_ready was low");
                    proto_err++;
                end
            end
            hold = commit_valid && !commit_ready;
            held = commit;
            if (commit_valid && commit_ready) begin
                check_commit(commit);
            end
            if (branch_valid) begin
                check_branch(branch);
            end
        end
    end

    initial begin
        commit_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            commit_ready = stall_en ? ($urandom % 3 != 0) : 1'b1;
        end
    end

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("timeout after %0d cycles, requests or commits are stuck", timeout_cycles);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h5132));
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        stall_en     = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        compare_field("commit_valid", 32'd0, 32'(commit_valid));
        compare_field("branch_valid", 32'd0, 32'(branch_valid));
        compare_field("req_ready", 32'd1, 32'(req_ready));
        @(posedge clk);
        #1;

        run_phase(60, 0, 1'b1);
        run_phase(40, 1, 1'b1);
        run_phase(32, 2, 1'b0);
        run_phase(60, 3, 1'b0);
        stall_en = 1'b1;                  // Random back-pressure on commit
        run_phase(48, 3, 1'b0);
        while (outstanding != 0) @(negedge clk);
        stall_en = 1'b0;
        repeat (20) @(negedge clk);       // Late duplicates would show here

        assert (exp_br.size() == 0) else begin
            $display("%0d branches never pulsed branch_valid", exp_br.size());
            proto_err++;
        end
        $display("errors: %0d value, %0d protocol; requests %0d, commits %0d, branches %0d",
                 value_err, proto_err, sent, committed, branches);
        if (value_err == 0 && proto_err == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
design/simt_alu_pkg.sv
design/alu_lane.sv
design/alu_pipe.sv
design/muldiv_unit.sv
design/commit_arb.sv
design/simt_alu_unit.sv
verif/simt_alu_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = simt_alu_tb
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
